// ==== all.f ====
+incdir+include
rtl/scratch_cfg_pkg.sv
rtl/axil_pkg.sv
rtl/single_port_lutram.sv
rtl/lookup_ctrl.sv
rtl/tagged_scratchpad.sv
bench/tagged_scratchpad_props.sv
bench/tb_tagged_scratchpad.sv

// ==== run.sh ====
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
    -f all.f --top-module tb_tagged_scratchpad -o sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Regression passed"; then
    exit 0
fi
exit 1

// ==== bench/tb_tagged_scratchpad.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_tagged_scratchpad;

    localparam int NUM_SET    = 16;
    localparam int WAIT_LIMIT = 64;

    logic                  clk_in;
    logic                  reset_in;
    axil_pkg::addr_chan_t  aw_ch;
    axil_pkg::wdata_chan_t w_ch;
    axil_pkg::addr_chan_t  ar_ch;
    axil_pkg::rdata_chan_t r_ch;
    axil_pkg::bresp_chan_t b_ch;
    axil_pkg::ready_t      m_ready;
    axil_pkg::ready_t      s_ready;

    integer seed;
    int     error_count;
    int     timeout_count;
    logic   backpressure;

    // reference model, one entry per set.
    logic [5:0]  model_tag [NUM_SET];
    logic        model_valid [NUM_SET];
    logic [31:0] model_word [NUM_SET];

    tagged_scratchpad #(
        .NUM_SET (NUM_SET)
    ) i_tagged_scratchpad (
        .clk_in       (clk_in),
        .reset_in     (reset_in),
        .aw           (aw_ch),
        .w            (w_ch),
        .ar           (ar_ch),
        .r            (r_ch),
        .b            (b_ch),
        .master_ready (m_ready),
        .slave_ready  (s_ready)
    );

    initial
    begin
        clk_in = 1'b0;
        forever #5 clk_in = ~clk_in;
    end

    function automatic logic [31:0] next_random();
        return $random(seed);
    endfunction

    // address bits 11:6 are the tag and 5:2 the set index.
    function automatic logic model_hit(input logic [11:0] addr);
        return model_valid[addr[5:2]] && (model_tag[addr[5:2]] == addr[11:6]);
    endfunction

    function automatic logic pick_ready();
        logic [31:0] rnd;
        rnd = next_random();
        return !backpressure || (rnd[1:0] == 2'd0);
    endfunction

    // outputs are sampled at the falling edge, where they are settled.
    task automatic await_response(input logic is_read, output logic done);
        int cycles;
        done   = 1'b0;
        cycles = 0;
        while (!done && cycles < WAIT_LIMIT)
        begin
            if (is_read)
            begin
                m_ready.r = pick_ready();
            end
            else
            begin
                m_ready.b = pick_ready();
            end
            @(negedge clk_in);
            done = is_read ? (r_ch.valid && m_ready.r) : (b_ch.valid && m_ready.b);
            if (!done)
            begin
                @(posedge clk_in);
                #1;
            end
            cycles++;
        end
        if (!done)
        begin
            timeout_count++;
            $display("Timeout: no %s response arrived at %0t.", is_read ? "read" : "write",
                     $time);
        end
    endtask

    task automatic read_check(input logic [11:0] addr);
        logic [31:0]     exp_data;
        axil_pkg::resp_t exp_resp;
        logic            done;
        int              cycles;
        exp_data    = model_hit(addr) ? model_word[addr[5:2]] : 32'h0;
        exp_resp    = model_hit(addr) ? axil_pkg::RESP_OKAY : axil_pkg::RESP_SLVERR;
        ar_ch.addr  = addr;
        ar_ch.valid = 1'b1;
        done        = 1'b0;
        cycles      = 0;
        while (!done && cycles < WAIT_LIMIT)
        begin
            @(negedge clk_in);
            done = s_ready.ar;
            @(posedge clk_in);
            #1;
            cycles++;
        end
        ar_ch.valid = 1'b0;
        if (!done)
        begin
            timeout_count++;
            $display("Timeout: read address was never accepted at %0t.", $time);
            return;
        end
        await_response(1'b1, done);
        if (done)
        begin
            assert (r_ch.data == exp_data && r_ch.resp == exp_resp)
            else
            begin
                error_count++;
                $display("** Error at %0t: read %h expected %h/%0d, got %h/%0d", $time, addr,
                         exp_data, exp_resp, r_ch.data, r_ch.resp);
            end
        end
        @(posedge clk_in);
        #1;
        m_ready.r = 1'b0;
    endtask

    // order 0 offers AW and W together, 1 sends AW first, 2 sends W first.
    task automatic write_check(input logic [11:0] addr, input logic [31:0] data,
                               input logic [3:0] strb, input int order);
        axil_pkg::resp_t exp_resp;
        logic            aw_done;
        logic            w_done;
        logic            aw_hs;
        logic            w_hs;
        logic            done;
        int              cycles;
        if (model_hit(addr))
        begin
            for (int lane = 0; lane < 4; lane++)
            begin
                if (strb[lane])
                begin
                    model_word[addr[5:2]][lane*8 +: 8] = data[lane*8 +: 8];
                end
            end
            exp_resp = axil_pkg::RESP_OKAY;
        end
        else if (strb == 4'hf)
        begin
            model_word[addr[5:2]]  = data;
            model_tag[addr[5:2]]   = addr[11:6];
            model_valid[addr[5:2]] = 1'b1;
            exp_resp               = axil_pkg::RESP_OKAY;
        end
        else
        begin
            exp_resp = axil_pkg::RESP_SLVERR;
        end
        aw_ch.addr  = addr;
        w_ch.data   = data;
        w_ch.strb   = strb;
        aw_ch.valid = (order != 2);
        w_ch.valid  = (order != 1);
        aw_done     = 1'b0;
        w_done      = 1'b0;
        cycles      = 0;
        while (!(aw_done && w_done) && cycles < WAIT_LIMIT)
        begin
            @(negedge clk_in);
            aw_hs = aw_ch.valid && s_ready.aw;
            w_hs  = w_ch.valid && s_ready.w;
            @(posedge clk_in);
            #1;
            if (aw_hs)
            begin
                aw_done     = 1'b1;
                aw_ch.valid = 1'b0;
            end
            if (w_hs)
            begin
                w_done     = 1'b1;
                w_ch.valid = 1'b0;
            end
            w_ch.valid  = w_ch.valid || (aw_done && !w_done);
            aw_ch.valid = aw_ch.valid || (w_done && !aw_done);
            cycles++;
        end
        if (!(aw_done && w_done))
        begin
            timeout_count++;
            $display("Timeout: write address or data was never accepted at %0t.", $time);
            return;
        end
        await_response(1'b0, done);
        if (done)
        begin
            assert (b_ch.resp == exp_resp)
            else
            begin
                error_count++;
                $display("** Error at %0t: write %h strb %h expected resp %0d, got %0d", $time,
                         addr, strb, exp_resp, b_ch.resp);
            end
        end
        @(posedge clk_in);
        #1;
        m_ready.b = 1'b0;
    endtask

    initial
    begin
        logic [31:0] rnd;
        logic [11:0] addr_a;
        logic [11:0] addr_b;
        seed          = 32'hd19b6520;
        error_count   = 0;
        timeout_count = 0;
        backpressure  = 1'b0;
        reset_in      = 1'b1;
        aw_ch         = '0;
        w_ch          = '0;
        ar_ch         = '0;
        m_ready       = '0;
        for (int i = 0; i < NUM_SET; i++)
        begin
            model_valid[i] = 1'b0;
        end
        repeat (8) @(posedge clk_in);
        #1;
        reset_in = 1'b0;
        @(posedge clk_in);
        #1;

        // every set starts empty, so any read misses.
        for (int i = 0; i < 8; i++)
        begin
            rnd = next_random();
            read_check(rnd[11:0]);
        end

        // two addresses that share set 3 under different tags.
        addr_a = {6'h05, 4'h3, 2'h0};
        addr_b = {6'h2a, 4'h3, 2'h0};
        write_check(addr_a, 32'h1234_5678, 4'hf, 0);
        read_check(addr_a);
        write_check(addr_a, 32'hcafe_f00d, 4'b0101, 1);
        read_check(addr_a);
        write_check(addr_b, 32'hdead_beef, 4'b0011, 2);
        read_check(addr_a);
        backpressure = 1'b1;
        write_check(addr_b, 32'hdead_beef, 4'hf, 0);
        read_check(addr_a);
        read_check(addr_b);

        // only four tags are used, so hits, merges and conflicts all occur.
        for (int i = 0; i < 300; i++)
        begin
            rnd          = next_random();
            backpressure = rnd[16];
            if (rnd[8])
            begin
                read_check({4'h0, rnd[1:0], rnd[5:2], rnd[7:6]});
            end
            else
            begin
                write_check({4'h0, rnd[1:0], rnd[5:2], rnd[7:6]}, next_random(),
                            rnd[9] ? 4'hf : rnd[13:10], int'(rnd[15:14]) % 3);
            end
        end

        $display("Checks done: %0d value errors, %0d timeouts", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0)
        begin
            $display("Regression passed");
        end
        else
        begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/tagged_scratchpad_props.sv ====
`timescale 1ns/1ns
`default_nettype none

module tagged_scratchpad_props
(
    input  logic                  clk_in,
    input  logic                  reset_in,
    input  axil_pkg::addr_chan_t  aw,
    input  axil_pkg::wdata_chan_t w,
    input  axil_pkg::addr_chan_t  ar,
    input  axil_pkg::rdata_chan_t r,
    input  axil_pkg::bresp_chan_t b,
    input  axil_pkg::ready_t      master_ready,
    input  axil_pkg::ready_t      slave_ready
);

    logic ar_fire;
    logic aw_fire;
    logic w_fire;
    logic aw_pend;
    logic w_pend;
    logic write_start;

    assign ar_fire     = ar.valid && slave_ready.ar;
    assign aw_fire     = aw.valid && slave_ready.aw;
    assign w_fire      = w.valid && slave_ready.w;
    assign write_start = (aw_pend || aw_fire) && (w_pend || w_fire);

    // a write starts on the edge where both its address and its data are in.
    always_ff @(posedge clk_in or posedge reset_in)
    begin
        if (reset_in)
        begin
            aw_pend <= 1'b0;
            w_pend  <= 1'b0;
        end
        else
        begin
            aw_pend <= (aw_pend || aw_fire) && !write_start;
            w_pend  <= (w_pend || w_fire) && !write_start;
        end
    end

    read_latency: assert property (@(posedge clk_in) disable iff (reset_in)
        ($past(ar_fire, 2) |-> r.valid) and ($rose(r.valid) |-> $past(ar_fire, 2)))
        else $error("read response did not follow the address handshake by two cycles");

    write_latency: assert property (@(posedge clk_in) disable iff (reset_in)
        ($past(write_start, 3) |-> b.valid) and ($rose(b.valid) |-> $past(write_start, 3)))
        else $error("write response did not follow the write start by three cycles");

    r_stable: assert property (@(posedge clk_in) disable iff (reset_in)
        r.valid && !master_ready.r |=> $stable(r))
        else $error("read response changed while it was waiting for ready");

    b_stable: assert property (@(posedge clk_in) disable iff (reset_in)
        b.valid && !master_ready.b |=> $stable(b))
        else $error("write response changed while it was waiting for ready");

    no_accept_busy: assert property (@(posedge clk_in) disable iff (reset_in)
        (r.valid || b.valid) |-> !(slave_ready.aw || slave_ready.w || slave_ready.ar))
        else $error("a request channel was ready while a response was pending");

endmodule

bind tagged_scratchpad tagged_scratchpad_props i_props
(
    .clk_in       (clk_in),
    .reset_in     (reset_in),
    .aw           (aw),
    .w            (w),
    .ar           (ar),
    .r            (r),
    .b            (b),
    .master_ready (master_ready),
    .slave_ready  (slave_ready)
);

`default_nettype wire

// ==== rtl/tagged_scratchpad.sv ====
`timescale 1ns/1ns
`default_nettype none

module tagged_scratchpad
#(
    parameter int NUM_SET = scratch_cfg_pkg::NUM_SET_DEFAULT
)
(
    input  logic                    clk_in,
    input  logic                    reset_in,
    input  axil_pkg::addr_chan_t    aw,
    input  axil_pkg::wdata_chan_t   w,
    input  axil_pkg::addr_chan_t    ar,
    output axil_pkg::rdata_chan_t   r,
    output axil_pkg::bresp_chan_t   b,
    input  axil_pkg::ready_t        master_ready,
    output axil_pkg::ready_t        slave_ready
);

    localparam int SET_W = $clog2(NUM_SET);

    logic                                    tag_access_en;
    logic [scratch_cfg_pkg::TAG_MASK_W-1:0]  tag_write_en;
    logic                                    data_access_en;
    logic [scratch_cfg_pkg::STRB_W-1:0]      data_write_en;
    logic [SET_W-1:0]                        set_addr;
    logic [scratch_cfg_pkg::TAG_ENTRY_W-1:0] tag_wr_entry;
    logic [scratch_cfg_pkg::DATA_W-1:0]      data_wr_entry;
    logic [scratch_cfg_pkg::TAG_ENTRY_W-1:0] tag_rd_entry;
    logic                                    tag_rd_valid;
    logic [scratch_cfg_pkg::DATA_W-1:0]      data_rd_entry;

    lookup_ctrl #(
        .NUM_SET (NUM_SET)
    ) i_lookup_ctrl (
        .clk_in         (clk_in),
        .reset_in       (reset_in),
        .aw             (aw),
        .w              (w),
        .ar             (ar),
        .r              (r),
        .b              (b),
        .master_ready   (master_ready),
        .slave_ready    (slave_ready),
        .tag_access_en  (tag_access_en),
        .tag_write_en   (tag_write_en),
        .data_access_en (data_access_en),
        .data_write_en  (data_write_en),
        .set_addr       (set_addr),
        .tag_wr_entry   (tag_wr_entry),
        .data_wr_entry  (data_wr_entry),
        .tag_rd_entry   (tag_rd_entry),
        .tag_rd_valid   (tag_rd_valid),
        .data_rd_entry  (data_rd_entry)
    );

    // the tag store's valid array doubles as the per-set presence bit.
    single_port_lutram #(
        .SINGLE_ENTRY_WIDTH_IN_BITS (scratch_cfg_pkg::TAG_ENTRY_W),
        .NUM_SET                    (NUM_SET),
        .WITH_VALID_REG_ARRAY       ("Yes")
    ) tag_store (
        .clk_in          (clk_in),
        .reset_in        (reset_in),
        .access_en       (tag_access_en),
        .write_en        (tag_write_en),
        .access_set_addr (set_addr),
        .write_entry     (tag_wr_entry),
        .read_entry      (tag_rd_entry),
        .read_valid      (tag_rd_valid)
    );

    single_port_lutram #(
        .SINGLE_ENTRY_WIDTH_IN_BITS (scratch_cfg_pkg::DATA_W),
        .NUM_SET                    (NUM_SET),
        .WITH_VALID_REG_ARRAY       ("No")
    ) data_store (
        .clk_in          (clk_in),
        .reset_in        (reset_in),
        .access_en       (data_access_en),
        .write_en        (data_write_en),
        .access_set_addr (set_addr),
        .write_entry     (data_wr_entry),
        .read_entry      (data_rd_entry),
        .read_valid      ()
    );

endmodule

`default_nettype wire

// ==== rtl/lookup_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module lookup_ctrl
#(
    parameter int  NUM_SET = 16,
    localparam int SET_W   = $clog2(NUM_SET)
)
(
    input  logic                                        clk_in,
    input  logic                                        reset_in,

    input  axil_pkg::addr_chan_t                        aw,
    input  axil_pkg::wdata_chan_t                       w,
    input  axil_pkg::addr_chan_t                        ar,
    output axil_pkg::rdata_chan_t                       r,
    output axil_pkg::bresp_chan_t                       b,
    input  axil_pkg::ready_t                            master_ready,
    output axil_pkg::ready_t                            slave_ready,

    output logic                                        tag_access_en,
    output logic [scratch_cfg_pkg::TAG_MASK_W-1:0]      tag_write_en,
    output logic                                        data_access_en,
    output logic [scratch_cfg_pkg::STRB_W-1:0]          data_write_en,
    output logic [SET_W-1:0]                            set_addr,
    output logic [scratch_cfg_pkg::TAG_ENTRY_W-1:0]     tag_wr_entry,
    output logic [scratch_cfg_pkg::DATA_W-1:0]          data_wr_entry,
    input  logic [scratch_cfg_pkg::TAG_ENTRY_W-1:0]     tag_rd_entry,
    input  logic                                        tag_rd_valid,
    input  logic [scratch_cfg_pkg::DATA_W-1:0]          data_rd_entry
);

    localparam logic [1:0] ST_IDLE    = 2'd0;
    localparam logic [1:0] ST_LOOKUP  = 2'd1;
    localparam logic [1:0] ST_DECIDE  = 2'd2;
    localparam logic [1:0] ST_RESPOND = 2'd3;

    // the set index is sliced out of the address union, so both must agree.
    if (SET_W != scratch_cfg_pkg::INDEX_W)
    begin : g_geometry_check
        $error("NUM_SET does not match the index width of scratch_cfg_pkg.");
    end

    logic [1:0]                              state;
    logic                                    is_write;
    logic                                    aw_held;
    logic                                    w_held;
    scratch_cfg_pkg::scratch_addr_u          req_addr;
    logic [scratch_cfg_pkg::DATA_W-1:0]      req_data;
    logic [scratch_cfg_pkg::STRB_W-1:0]      req_strb;
    axil_pkg::resp_t                         b_resp_q;

    logic idle;
    logic aw_fire;
    logic w_fire;
    logic ar_fire;
    logic aw_have;
    logic w_have;
    logic start_write;
    logic hit;
    logic full_strb;
    logic write_ok;

    assign idle    = (state == ST_IDLE);
    assign aw_fire = aw.valid && slave_ready.aw;
    assign w_fire  = w.valid && slave_ready.w;
    assign ar_fire = ar.valid && slave_ready.ar;

    assign aw_have     = aw_held || aw_fire;
    assign w_have      = w_held || w_fire;
    assign start_write = idle && aw_have && w_have;

    // a stored tag only counts when the set has been written at least once.
    assign hit = tag_rd_valid
              && (tag_rd_entry == scratch_cfg_pkg::TAG_ENTRY_W'(req_addr.fields.tag));
    assign full_strb = &req_strb;
    assign write_ok  = hit || full_strb;

    always_ff @(posedge clk_in or posedge reset_in)
    begin
        if (reset_in)
        begin
            state    <= ST_IDLE;
            is_write <= 1'b0;
            aw_held  <= 1'b0;
            w_held   <= 1'b0;
        end
        else
        begin
            case (state)
                ST_IDLE:
                begin
                    if (start_write)
                    begin
                        state    <= ST_LOOKUP;
                        is_write <= 1'b1;
                        aw_held  <= 1'b0;
                        w_held   <= 1'b0;
                    end
                    else
                    begin
                        aw_held <= aw_have;
                        w_held  <= w_have;
                        if (ar_fire)
                        begin
                            state    <= ST_LOOKUP;
                            is_write <= 1'b0;
                        end
                    end
                end
                ST_LOOKUP:
                begin
                    // reads answer straight from the store outputs.
                    state <= is_write ? ST_DECIDE : ST_RESPOND;
                end
                ST_DECIDE:
                begin
                    state <= ST_RESPOND;
                end
                default:
                begin
                    if (is_write ? master_ready.b : master_ready.r)
                    begin
                        state <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (aw_fire)
        begin
            req_addr.raw <= aw.addr;
        end
        if (ar_fire)
        begin
            req_addr.raw <= ar.addr;
        end
        if (w_fire)
        begin
            req_data <= w.data;
            req_strb <= w.strb;
        end
        if (state == ST_DECIDE)
        begin
            b_resp_q <= write_ok ? axil_pkg::RESP_OKAY : axil_pkg::RESP_SLVERR;
        end
    end

    always_comb
    begin
        // reads wait while any part of a write is offered or held.
        slave_ready    = '0;
        slave_ready.aw = idle && !aw_held;
        slave_ready.w  = idle && !w_held;
        slave_ready.ar = idle && !aw_held && !w_held && !aw.valid && !w.valid;

        tag_access_en  = (state == ST_LOOKUP) || (state == ST_DECIDE);
        data_access_en = tag_access_en;
        set_addr       = req_addr.fields.index;
        tag_wr_entry   = scratch_cfg_pkg::TAG_ENTRY_W'(req_addr.fields.tag);
        data_wr_entry  = req_data;

        tag_write_en  = '0;
        data_write_en = '0;
        if (state == ST_DECIDE)
        begin
            if (hit)
            begin
                data_write_en = req_strb;
            end
            else if (full_strb)
            begin
                data_write_en = '1;
                tag_write_en  = '1;
            end
        end

        r.valid = (state == ST_RESPOND) && !is_write;
        r.data  = hit ? data_rd_entry : '0;
        r.resp  = hit ? axil_pkg::RESP_OKAY : axil_pkg::RESP_SLVERR;

        b.valid = (state == ST_RESPOND) && is_write;
        b.resp  = b_resp_q;
    end

endmodule

`default_nettype wire

// ==== rtl/single_port_lutram.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "lut_defs.svh"

module single_port_lutram
#(
    parameter int    SINGLE_ENTRY_WIDTH_IN_BITS = 64,
    parameter int    NUM_SET                    = 64,
    parameter string WITH_VALID_REG_ARRAY       = "Yes",
    localparam int   SET_PTR_WIDTH_IN_BITS      = $clog2(NUM_SET),
    localparam int   WRITE_MASK_LEN             = SINGLE_ENTRY_WIDTH_IN_BITS / `BYTE_LEN_IN_BITS
)
(
    input  logic                                    clk_in,
    input  logic                                    reset_in,

    input  logic                                    access_en,
    input  logic [WRITE_MASK_LEN-1:0]               write_en,
    input  logic [SET_PTR_WIDTH_IN_BITS-1:0]        access_set_addr,

    input  logic [SINGLE_ENTRY_WIDTH_IN_BITS-1:0]   write_entry,
    output logic [SINGLE_ENTRY_WIDTH_IN_BITS-1:0]   read_entry,
    output logic                                    read_valid
);

    logic [SINGLE_ENTRY_WIDTH_IN_BITS-1:0] lut_ram [NUM_SET];

    generate
        if (WITH_VALID_REG_ARRAY == "Yes")
        begin : g_valid_array
            logic [NUM_SET-1:0] valid_array;

            always_ff @(posedge clk_in or posedge reset_in)
            begin
                if (reset_in)
                begin
                    valid_array <= '0;
                    read_valid  <= 1'b0;
                end
                else if (access_en)
                begin
                    // any lane written marks the whole set as present.
                    if (|write_en)
                    begin
                        valid_array[access_set_addr] <= 1'b1;
                    end
                    // read_valid holds between accesses so a waiting response stays stable.
                    read_valid <= valid_array[access_set_addr];
                end
            end
        end
        else
        begin : g_no_valid_array
            assign read_valid = 1'b1;
        end
    endgenerate

    always_ff @(posedge clk_in)
    begin
        for (int lane = 0; lane < WRITE_MASK_LEN; lane++)
        begin
            if (access_en && write_en[lane])
            begin
                lut_ram[access_set_addr][lane*`BYTE_LEN_IN_BITS +: `BYTE_LEN_IN_BITS]
                    <= write_entry[lane*`BYTE_LEN_IN_BITS +: `BYTE_LEN_IN_BITS];
            end
        end
    end

    assign read_entry = lut_ram[access_set_addr];

endmodule

`default_nettype wire

// ==== rtl/axil_pkg.sv ====
`default_nettype none

package axil_pkg;

    typedef logic [1:0] resp_t;

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;

    // shared by the AW and AR channels.
    typedef struct packed {
        logic                                valid;
        logic [scratch_cfg_pkg::ADDR_W-1:0]  addr;
    } addr_chan_t;

    typedef struct packed {
        logic                                valid;
        logic [scratch_cfg_pkg::DATA_W-1:0]  data;
        logic [scratch_cfg_pkg::STRB_W-1:0]  strb;
    } wdata_chan_t;

    typedef struct packed {
        logic                                valid;
        logic [scratch_cfg_pkg::DATA_W-1:0]  data;
        resp_t                               resp;
    } rdata_chan_t;

    typedef struct packed {
        logic  valid;
        resp_t resp;
    } bresp_chan_t;

    // the slave drives aw, w and ar, the master drives r and b.
    typedef struct packed {
        logic aw;
        logic w;
        logic ar;
        logic r;
        logic b;
    } ready_t;

endpackage

`default_nettype wire

// ==== rtl/scratch_cfg_pkg.sv ====
`default_nettype none

`include "lut_defs.svh"

package scratch_cfg_pkg;

    localparam int ADDR_W          = 12;
    localparam int DATA_W          = 32;
    localparam int STRB_W          = DATA_W / `BYTE_LEN_IN_BITS;
    localparam int OFFSET_W        = 2;
    localparam int NUM_SET_DEFAULT = 16;
    localparam int INDEX_W         = $clog2(NUM_SET_DEFAULT);
    localparam int TAG_W           = ADDR_W - INDEX_W - OFFSET_W;

    // the tag lives in the low bits of a single byte lane.
    localparam int TAG_ENTRY_W     = `BYTE_LEN_IN_BITS;
    localparam int TAG_MASK_W      = TAG_ENTRY_W / `BYTE_LEN_IN_BITS;

    typedef struct packed {
        logic [TAG_W-1:0]    tag;
        logic [INDEX_W-1:0]  index;
        logic [OFFSET_W-1:0] offset;
    } addr_fields_t;

    typedef union packed {
        logic [ADDR_W-1:0] raw;
        addr_fields_t      fields;
    } scratch_addr_u;

endpackage

`default_nettype wire

// ==== include/lut_defs.svh ====
`ifndef LUT_DEFS_SVH
`define LUT_DEFS_SVH

// one write-enable bit covers this many data bits.
`define BYTE_LEN_IN_BITS 8

`endif
